// File: all.f
hw/c64_mem_pkg.sv
hw/c64_load_pkg.sv
hw/mem_port_if.sv
hw/shared_ram.sv
hw/mem_arbiter.sv
hw/prg_loader.sv
hw/tape_player.sv
hw/c64_mem_hub.sv
verification/tb_top.sv

// File: hw/c64_load_pkg.sv
package c64_load_pkg;

	// ==================================================
	// Download file types, numbered as in the OSD menu
	// ==================================================
	typedef enum logic [7:0] {
		DL_PRG = 8'd4,
		DL_TAP = 8'd6
	} dl_index_e;

	// Program loader phases
	typedef enum logic [2:0] {
		LD_IDLE,
		LD_HDR_LO,
		LD_HDR_HI,
		LD_DATA,
		LD_INJECT
	} loader_state_e;

	// Tape transport
	typedef enum logic [1:0] {
		TP_EMPTY,
		TP_STOPPED,
		TP_PLAYING
	} tape_state_e;

endpackage

// File: hw/c64_mem_hub.sv
`timescale 1ns/1ps

module c64_mem_hub
	import c64_mem_pkg::*;
	import c64_load_pkg::*;
#(
	parameter int                ADDR_W     = ADDR_W_DEF,
	parameter logic [ADDR_W-1:0] TAP_BASE   = ADDR_W'(TAP_BASE_DEF),
	parameter int                TAPE_TICK  = 4,
	parameter int                FIFO_DEPTH = 4
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dl_active_i,
	input  logic [7:0]        dl_index_i,
	input  logic              dl_wr_i,
	input  logic [ADDR_W-1:0] dl_addr_i,
	input  logic [7:0]        dl_data_i,
	input  logic              cpu_strobe_i,
	input  logic              cpu_we_i,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic [7:0]        cpu_wdata_i,
	output logic [7:0]        cpu_rdata_o,
	output logic              cpu_rvalid_o,
	input  logic              tape_play_i,
	output logic              cass_pulse_o,
	output logic              tape_loaded_o,
	output logic              tape_playing_o,
	output logic              load_busy_o
);

	mem_port_if #(.ADDR_W(ADDR_W)) host_port ();
	mem_port_if #(.ADDR_W(ADDR_W)) load_port ();
	mem_port_if #(.ADDR_W(ADDR_W)) tape_port ();

	logic              ram_en;
	logic              ram_we;
	logic [ADDR_W-1:0] ram_addr;
	byte_t             ram_wdata;
	byte_t             ram_rdata;
	logic              tap_done;
	logic [ADDR_W-1:0] tap_len;

	// Host has top priority, its strobe is always served at once
	assign host_port.req   = cpu_strobe_i;
	assign host_port.we    = cpu_we_i;
	assign host_port.addr  = cpu_addr_i;
	assign host_port.wdata = cpu_wdata_i;
	assign cpu_rdata_o     = host_port.rdata;
	assign cpu_rvalid_o    = host_port.rvalid;

	mem_arbiter #(.ADDR_W(ADDR_W)) arb0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.host        (host_port.arbiter),
		.load        (load_port.arbiter),
		.tape        (tape_port.arbiter),
		.ram_en_o    (ram_en),
		.ram_we_o    (ram_we),
		.ram_addr_o  (ram_addr),
		.ram_wdata_o (ram_wdata),
		.ram_rdata_i (ram_rdata)
	);

	shared_ram #(.ADDR_W(ADDR_W)) ram0 (
		.clk_sys (clk_sys),
		.en_i    (ram_en),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	prg_loader #(.ADDR_W(ADDR_W), .TAP_BASE(TAP_BASE)) loader0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_e'(dl_index_i)),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.mem         (load_port.requester),
		.tap_done_o  (tap_done),
		.tap_len_o   (tap_len),
		.load_busy_o (load_busy_o)
	);

	tape_player #(
		.ADDR_W     (ADDR_W),
		.TAP_BASE   (TAP_BASE),
		.TAPE_TICK  (TAPE_TICK),
		.FIFO_DEPTH (FIFO_DEPTH)
	) tape0 (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.tap_done_i     (tap_done),
		.tap_len_i      (tap_len),
		.tape_play_i    (tape_play_i),
		.mem            (tape_port.requester),
		.cass_pulse_o   (cass_pulse_o),
		.tape_loaded_o  (tape_loaded_o),
		.tape_playing_o (tape_playing_o)
	);

endmodule

// File: hw/c64_mem_pkg.sv
package c64_mem_pkg;

	// ==================================================
	// Basic types of the shared memory
	// ==================================================
	typedef logic [7:0] byte_t;

	// 64K main RAM plus a second 64K bank for the tape image
	localparam int ADDR_W_DEF = 17;

	localparam logic [16:0] TAP_BASE_DEF = 17'h10000;

	// ==================================================
	// BASIC zero page pointers, low byte address given
	// ==================================================
	localparam logic [15:0] PTR_TXT = 16'h002B;
	localparam logic [15:0] PTR_VAR = 16'h002D;
	localparam logic [15:0] PTR_ARY = 16'h002F;
	localparam logic [15:0] PTR_STR = 16'h0031;
	localparam logic [15:0] PTR_SAVE = 16'h00AC;
	localparam logic [15:0] PTR_LOAD_END = 16'h00AE;

	// Start of BASIC text after a cold start
	localparam logic [15:0] TXT_START_DEF = 16'h0801;

endpackage

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF
) (
	input  logic              clk_sys,
	input  logic              RESET,
	mem_port_if.arbiter       host,
	mem_port_if.arbiter       load,
	mem_port_if.arbiter       tape,
	output logic              ram_en_o,
	output logic              ram_we_o,
	output logic [ADDR_W-1:0] ram_addr_o,
	output byte_t             ram_wdata_o,
	input  byte_t             ram_rdata_i
);

	// One bit per requester that had a read granted last cycle
	// bit 0 host, bit 1 loader, bit 2 tape
	logic [2:0] rd_owner;

	// ==================================================
	// Fixed priority select, host > loader > tape
	// ==================================================
	always_comb begin
		host.gnt = host.req;
		load.gnt = load.req && !host.req;
		tape.gnt = tape.req && !host.req && !load.req;

		ram_en_o = host.req || load.req || tape.req;

		if (host.req) begin
			ram_we_o    = host.we;
			ram_addr_o  = host.addr;
			ram_wdata_o = host.wdata;
		end else if (load.req) begin
			ram_we_o    = load.we;
			ram_addr_o  = load.addr;
			ram_wdata_o = load.wdata;
		end else begin
			ram_we_o    = tape.we;
			ram_addr_o  = tape.addr;
			ram_wdata_o = tape.wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_owner <= '0;
		end else begin
			rd_owner[0] <= host.gnt && !host.we;
			rd_owner[1] <= load.gnt && !load.we;
			rd_owner[2] <= tape.gnt && !tape.we;
		end
	end

	// RAM output is shared, rvalid tells whose read it is
	assign host.rdata  = ram_rdata_i;
	assign load.rdata  = ram_rdata_i;
	assign tape.rdata  = ram_rdata_i;

	assign host.rvalid = rd_owner[0];
	assign load.rvalid = rd_owner[1];
	assign tape.rvalid = rd_owner[2];

endmodule

// File: hw/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF
) ();

	// Request side, held until gnt
	logic              req;
	logic              we;
	logic [ADDR_W-1:0] addr;
	byte_t             wdata;

	// Arbiter side
	logic              gnt;
	byte_t             rdata;
	logic              rvalid;

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

// File: hw/prg_loader.sv
`timescale 1ns/1ps

module prg_loader
	import c64_mem_pkg::*;
	import c64_load_pkg::*;
#(
	parameter int                ADDR_W   = ADDR_W_DEF,
	parameter logic [ADDR_W-1:0] TAP_BASE = ADDR_W'(TAP_BASE_DEF)
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dl_active_i,
	input  dl_index_e         dl_index_i,
	input  logic              dl_wr_i,
	input  logic [ADDR_W-1:0] dl_addr_i,
	input  byte_t             dl_data_i,
	mem_port_if.requester     mem,
	output logic              tap_done_o,
	output logic [ADDR_W-1:0] tap_len_o,
	output logic              load_busy_o
);

	loader_state_e     state;
	loader_state_e     phase;
	logic              tap_mode;
	logic              tap_now;
	logic [15:0]       wr_addr;
	logic [ADDR_W-1:0] tap_cnt;
	logic [3:0]        inj_idx;
	logic [15:0]       inj_ptr;
	logic [15:0]       inj_val;
	logic [15:0]       inj_addr;
	byte_t             inj_data;

	// A download may start with its first strobe, so IDLE forwards
	// straight into the entry phase of the file type
	always_comb begin
		phase = state;
		if (state == LD_IDLE && dl_active_i) begin
			if (dl_index_i == DL_PRG) begin
				phase = LD_HDR_LO;
			end else if (dl_index_i == DL_TAP) begin
				phase = LD_DATA;
			end
		end
	end

	assign tap_now = (state == LD_IDLE) ? (dl_index_i == DL_TAP) : tap_mode;

	// ==================================================
	// BASIC pointer table, as a LOAD command leaves it
	// ==================================================
	always_comb begin
		case (inj_idx[3:1])
			3'd0: begin
				inj_ptr = PTR_TXT;
				inj_val = TXT_START_DEF;
			end
			3'd1: begin
				inj_ptr = PTR_SAVE;
				inj_val = 16'h0000;
			end
			3'd2: begin
				inj_ptr = PTR_VAR;
				inj_val = wr_addr;
			end
			3'd3: begin
				inj_ptr = PTR_ARY;
				inj_val = wr_addr;
			end
			3'd4: begin
				inj_ptr = PTR_STR;
				inj_val = wr_addr;
			end
			default: begin
				inj_ptr = PTR_LOAD_END;
				inj_val = wr_addr;
			end
		endcase
		inj_addr = inj_ptr + 16'(inj_idx[0]);
		inj_data = inj_idx[0] ? inj_val[15:8] : inj_val[7:0];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state       <= LD_IDLE;
			tap_mode    <= 1'b0;
			mem.req     <= 1'b0;
			tap_done_o  <= 1'b0;
			load_busy_o <= 1'b0;
		end else begin
			tap_done_o <= 1'b0;
			if (mem.gnt) begin
				mem.req <= 1'b0;
			end
			if (state == LD_IDLE) begin
				tap_mode <= (dl_index_i == DL_TAP);
			end
			state <= phase;

			case (phase)
				LD_IDLE: begin
					tap_cnt <= '0;
					if (!mem.req || mem.gnt) begin
						load_busy_o <= 1'b0;
					end
				end
				// Load address, low byte first
				LD_HDR_LO: begin
					if (dl_wr_i) begin
						wr_addr[7:0] <= dl_data_i;
						load_busy_o  <= 1'b1;
						state        <= LD_HDR_HI;
					end else if (!dl_active_i) begin
						state <= LD_IDLE;
					end
				end
				LD_HDR_HI: begin
					if (dl_wr_i) begin
						wr_addr[15:8] <= dl_data_i;
						state         <= LD_DATA;
					end else if (!dl_active_i) begin
						state <= LD_IDLE;
					end
				end
				LD_DATA: begin
					if (dl_wr_i) begin
						load_busy_o <= 1'b1;
						mem.req     <= 1'b1;
						mem.wdata   <= dl_data_i;
						if (tap_now) begin
							mem.addr <= TAP_BASE + dl_addr_i;
							tap_cnt  <= tap_cnt + 1'b1;
						end else begin
							// wr_addr ends up as the load end address
							mem.addr <= ADDR_W'(wr_addr);
							wr_addr  <= wr_addr + 16'd1;
						end
					end
					if (!dl_active_i) begin
						if (tap_now) begin
							tap_done_o <= 1'b1;
							state      <= LD_IDLE;
						end else begin
							inj_idx <= '0;
							state   <= LD_INJECT;
						end
					end
				end
				LD_INJECT: begin
					if (!mem.req || mem.gnt) begin
						mem.req   <= 1'b1;
						mem.addr  <= ADDR_W'(inj_addr);
						mem.wdata <= inj_data;
						inj_idx   <= inj_idx + 4'd1;
						if (inj_idx == 4'd11) begin
							state <= LD_IDLE;
						end
					end
				end
			endcase
		end
	end

	assign mem.we    = 1'b1;
	assign tap_len_o = tap_cnt;

endmodule

// File: hw/shared_ram.sv
`timescale 1ns/1ps

module shared_ram
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF
) (
	input  logic              clk_sys,
	input  logic              en_i,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  byte_t             wdata_i,
	output byte_t             rdata_o
);

	localparam int DEPTH = 1 << ADDR_W;

	byte_t mem [0:DEPTH-1];

	// Single port, read data one cycle after the access
	always_ff @(posedge clk_sys) begin
		if (en_i) begin
			if (we_i) begin
				mem[addr_i] <= wdata_i;
			end
			rdata_o <= mem[addr_i];
		end
	end

endmodule

// File: hw/tape_player.sv
`timescale 1ns/1ps

module tape_player
	import c64_mem_pkg::*;
	import c64_load_pkg::*;
#(
	parameter int                ADDR_W     = ADDR_W_DEF,
	parameter logic [ADDR_W-1:0] TAP_BASE   = ADDR_W'(TAP_BASE_DEF),
	parameter int                TAPE_TICK  = 4,
	parameter int                FIFO_DEPTH = 4
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              tap_done_i,
	input  logic [ADDR_W-1:0] tap_len_i,
	input  logic              tape_play_i,
	mem_port_if.requester     mem,
	output logic              cass_pulse_o,
	output logic              tape_loaded_o,
	output logic              tape_playing_o
);

	localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int TICK_W = $clog2(TAPE_TICK + 1);

	tape_state_e       state;
	logic [ADDR_W-1:0] fetch_addr;
	logic [ADDR_W-1:0] fetch_left;
	logic [ADDR_W-1:0] play_left;
	logic              rd_wait;
	logic              discard;
	byte_t             fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W:0]    fifo_cnt;
	logic              timer_active;
	logic [8:0]        units;
	logic [TICK_W-1:0] tick;
	logic              playing;
	logic              push;
	logic              pop;
	logic              fire;
	logic              fetch_go;
	byte_t             head;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		playing = (state == TP_PLAYING);
		head    = fifo_mem[rd_ptr];
		push    = rd_wait && mem.rvalid && !discard;
		fire    = playing && timer_active && (tick == '0) && (units == 9'd1);
		// Reload in the pulse cycle keeps intervals back to back
		pop     = (fifo_cnt != '0) && (!timer_active || fire);
		// Only one read in flight, so one free slot is enough
		fetch_go = (state != TP_EMPTY) && (fetch_left != '0) && !mem.req && !rd_wait &&
			!discard && (fifo_cnt < FIFO_DEPTH);
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo_mem[wr_ptr] <= mem.rdata;
		end
	end

	// ==================================================
	// Fetch, queue and pulse timing
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state        <= TP_EMPTY;
			mem.req      <= 1'b0;
			rd_wait      <= 1'b0;
			discard      <= 1'b0;
			fetch_left   <= '0;
			play_left    <= '0;
			rd_ptr       <= '0;
			wr_ptr       <= '0;
			fifo_cnt     <= '0;
			timer_active <= 1'b0;
			cass_pulse_o <= 1'b0;
		end else begin
			if (mem.gnt) begin
				mem.req <= 1'b0;
				rd_wait <= 1'b1;
			end
			if (mem.rvalid) begin
				rd_wait <= 1'b0;
				discard <= 1'b0;
			end

			if (tap_done_i) begin
				// Rewind; a read of the old image still in flight gets dropped
				state        <= (tap_len_i != '0) ? TP_PLAYING : TP_EMPTY;
				fetch_addr   <= '0;
				fetch_left   <= tap_len_i;
				play_left    <= tap_len_i;
				rd_ptr       <= '0;
				wr_ptr       <= '0;
				fifo_cnt     <= '0;
				timer_active <= 1'b0;
				cass_pulse_o <= 1'b0;
				discard      <= mem.req || (rd_wait && !mem.rvalid);
			end else begin
				cass_pulse_o <= fire;

				if (fetch_go) begin
					mem.req    <= 1'b1;
					mem.addr   <= TAP_BASE + fetch_addr;
					fetch_addr <= fetch_addr + 1'b1;
					fetch_left <= fetch_left - 1'b1;
				end

				if (push) begin
					wr_ptr <= next_ptr(wr_ptr);
				end
				fifo_cnt <= fifo_cnt + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);

				// Byte value 0 stands for 256 units
				if (pop) begin
					rd_ptr       <= next_ptr(rd_ptr);
					units        <= (head == 8'd0) ? 9'd256 : {1'b0, head};
					tick         <= TICK_W'(TAPE_TICK - 1);
					timer_active <= 1'b1;
				end else if (fire) begin
					timer_active <= 1'b0;
				end else if (playing && timer_active) begin
					if (tick == '0) begin
						tick  <= TICK_W'(TAPE_TICK - 1);
						units <= units - 9'd1;
					end else begin
						tick <= tick - 1'b1;
					end
				end

				if (fire) begin
					play_left <= play_left - 1'b1;
				end

				if (fire && play_left == ADDR_W'(1)) begin
					state <= TP_EMPTY;
				end else if (tape_play_i && state == TP_PLAYING) begin
					state <= TP_STOPPED;
				end else if (tape_play_i && state == TP_STOPPED) begin
					state <= TP_PLAYING;
				end
			end
		end
	end

	assign mem.we         = 1'b0;
	assign mem.wdata      = '0;
	assign tape_loaded_o  = (state != TP_EMPTY);
	assign tape_playing_o = playing;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top
out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
else
	exit 1
fi

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top
	import c64_mem_pkg::*;
	import c64_load_pkg::*;
();

	localparam int          TICK      = 4;
	localparam logic [16:0] TAPE_BASE = 17'h10000;
	localparam logic [16:0] HOST_BASE = 17'h09000;
	// Pause outlasts the longest pulse interval
	localparam int          PAUSE_CYC = 256 * TICK + 50;

	logic        clk_sys = 1'b0;
	logic        RESET;
	logic        dl_active_i;
	logic [7:0]  dl_index_i;
	logic        dl_wr_i;
	logic [16:0] dl_addr_i;
	logic [7:0]  dl_data_i;
	logic        cpu_strobe_i;
	logic        cpu_we_i;
	logic [16:0] cpu_addr_i;
	logic [7:0]  cpu_wdata_i;
	logic [7:0]  cpu_rdata_o;
	logic        cpu_rvalid_o;
	logic        tape_play_i;
	logic        cass_pulse_o;
	logic        tape_loaded_o;
	logic        tape_playing_o;
	logic        load_busy_o;

	// Reference copy of the shared memory
	byte_t       model_mem [0:(1 << 17) - 1];
	logic [16:0] written_q [$];
	byte_t       prg_data [$];
	byte_t       tap_data [$];
	int          pulse_cyc [$];
	int          cyc = 0;
	int          limit = 0;
	int          errors = 0;
	int          test_errs = 0;
	int          checks = 0;
	logic [15:0] load_addr;
	logic        dl_done;

	c64_mem_hub dut0 (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.cpu_strobe_i   (cpu_strobe_i),
		.cpu_we_i       (cpu_we_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_wdata_i    (cpu_wdata_i),
		.cpu_rdata_o    (cpu_rdata_o),
		.cpu_rvalid_o   (cpu_rvalid_o),
		.tape_play_i    (tape_play_i),
		.cass_pulse_o   (cass_pulse_o),
		.tape_loaded_o  (tape_loaded_o),
		.tape_playing_o (tape_playing_o),
		.load_busy_o    (load_busy_o)
	);

	always #5 clk_sys = ~clk_sys;

	// Cycle counter and watchdog
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (limit != 0 && cyc >= limit) begin
			$display("Timeout, the tests did not finish within %0d cycles", limit);
			$display("sim failed");
			$finish;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished with %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	task automatic host_write(input logic [16:0] addr, input byte_t data);
		@(negedge clk_sys);
		cpu_strobe_i = 1'b1;
		cpu_we_i     = 1'b1;
		cpu_addr_i   = addr;
		cpu_wdata_i  = data;
		@(negedge clk_sys);
		cpu_strobe_i = 1'b0;
		model_mem[addr] = data;
		written_q.push_back(addr);
	endtask

	// Read data comes back in the cycle after the strobe
	task automatic read_check(input logic [16:0] addr, input byte_t exp);
		@(negedge clk_sys);
		cpu_strobe_i = 1'b1;
		cpu_we_i     = 1'b0;
		cpu_addr_i   = addr;
		@(negedge clk_sys);
		cpu_strobe_i = 1'b0;
		check_eq("cpu_rvalid_o", cpu_rvalid_o, 1);
		check_eq("cpu_rdata_o", cpu_rdata_o, exp);
	endtask

	task automatic read_host_random();
		logic [16:0] a;
		a = written_q[$urandom % written_q.size()];
		read_check(a, model_mem[a]);
	endtask

	// One download strobe with a gap of 4 to 7 cycles to the next
	task automatic send_dl(input logic [16:0] addr, input byte_t data);
		int gap;
		gap = 4 + ($urandom % 4);
		@(negedge clk_sys);
		dl_wr_i   = 1'b1;
		dl_addr_i = addr;
		dl_data_i = data;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		repeat (gap - 2) @(negedge clk_sys);
	endtask

	initial begin
		int          n_tap;
		int          tap_sum;
		int          prg_len;
		int          h;
		int          pause_left;
		int          extra;
		logic [15:0] end_addr;
		logic [16:0] a;
		byte_t       d;

		void'($urandom(32'h878e235f));
		RESET        = 1'b1;
		dl_active_i  = 1'b0;
		dl_index_i   = 8'd0;
		dl_wr_i      = 1'b0;
		dl_addr_i    = '0;
		dl_data_i    = 8'd0;
		cpu_strobe_i = 1'b0;
		cpu_we_i     = 1'b0;
		cpu_addr_i   = '0;
		cpu_wdata_i  = 8'd0;
		tape_play_i  = 1'b0;

		// Both images are drawn before the run starts
		load_addr = 16'h1000 + 16'($urandom % 32'h6000);
		prg_len   = 20 + ($urandom % 41);
		for (int i = 0; i < prg_len; i++) begin
			prg_data.push_back(byte_t'($urandom));
		end
		n_tap   = 6 + ($urandom % 5);
		tap_sum = 0;
		for (int i = 0; i < n_tap; i++) begin
			d = byte_t'(16 + ($urandom % 240));
			tap_data.push_back(d);
			tap_sum += d;
		end
		limit = tap_sum * TICK + 40 * (prg_len + 2 + n_tap) + 5000;

		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;

		repeat (5) begin
			@(negedge clk_sys);
			check_eq("cpu_rvalid_o", cpu_rvalid_o, 0);
			check_eq("load_busy_o", load_busy_o, 0);
			check_eq("cass_pulse_o", cass_pulse_o, 0);
			check_eq("tape_loaded_o", tape_loaded_o, 0);
			check_eq("tape_playing_o", tape_playing_o, 0);
		end
		report_test("reset");

		repeat (200) begin
			if (written_q.size() == 0 || ($urandom % 2) == 1) begin
				a = HOST_BASE + 17'($urandom % 256);
				host_write(a, byte_t'($urandom));
			end else begin
				read_host_random();
			end
		end
		report_test("host access");

		// ==================================================
		// PRG download with host reads running alongside
		// ==================================================
		dl_done = 1'b0;
		fork
			begin
				@(negedge clk_sys);
				dl_index_i  = DL_PRG;
				dl_active_i = 1'b1;
				send_dl(17'd0, load_addr[7:0]);
				send_dl(17'd1, load_addr[15:8]);
				for (int i = 0; i < prg_len; i++) begin
					a = {1'b0, load_addr + 16'(i)};
					model_mem[a] = prg_data[i];
					send_dl(17'(i + 2), prg_data[i]);
				end
				check_eq("load_busy_o", load_busy_o, 1);
				@(negedge clk_sys);
				dl_active_i = 1'b0;
				dl_done     = 1'b1;
			end
			begin
				while (!dl_done) read_host_random();
			end
		join
		while (load_busy_o) @(negedge clk_sys);
		for (int i = 0; i < prg_len; i++) begin
			a = {1'b0, load_addr + 16'(i)};
			read_check(a, model_mem[a]);
		end
		report_test("prg load");

		// Pointers as a LOAD command leaves them
		end_addr = load_addr + 16'(prg_len);
		read_check(17'h0002B, 8'h01);
		read_check(17'h0002C, 8'h08);
		read_check(17'h000AC, 8'h00);
		read_check(17'h000AD, 8'h00);
		read_check(17'h0002D, end_addr[7:0]);
		read_check(17'h0002E, end_addr[15:8]);
		read_check(17'h0002F, end_addr[7:0]);
		read_check(17'h00030, end_addr[15:8]);
		read_check(17'h00031, end_addr[7:0]);
		read_check(17'h00032, end_addr[15:8]);
		read_check(17'h000AE, end_addr[7:0]);
		read_check(17'h000AF, end_addr[15:8]);
		report_test("basic pointers");

		// ==================================================
		// TAP download and playback with one pause
		// ==================================================
		@(negedge clk_sys);
		dl_index_i  = DL_TAP;
		dl_active_i = 1'b1;
		for (int i = 0; i < n_tap; i++) begin
			model_mem[TAPE_BASE + 17'(i)] = tap_data[i];
			send_dl(17'(i), tap_data[i]);
		end
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		while (!tape_playing_o) @(negedge clk_sys);
		check_eq("tape_loaded_o", tape_loaded_o, 1);

		h          = n_tap / 2;
		pause_left = 0;
		while (pulse_cyc.size() < n_tap) begin
			@(negedge clk_sys);
			tape_play_i = 1'b0;
			if (pause_left > 0) begin
				check_eq("tape_playing_o", tape_playing_o, 0);
				check_eq("cass_pulse_o", cass_pulse_o, 0);
				pause_left--;
				if (pause_left == 0) begin
					tape_play_i = 1'b1;
				end
			end else if (cass_pulse_o) begin
				pulse_cyc.push_back(cyc);
				if (pulse_cyc.size() == h) begin
					tape_play_i = 1'b1;
					pause_left  = PAUSE_CYC;
				end
			end
		end
		// The frozen timer stretches the interval across the pause
		for (int k = 1; k < n_tap; k++) begin
			check_eq("pulse interval", pulse_cyc[k] - pulse_cyc[k - 1],
				tap_data[k] * TICK + ((k == h) ? PAUSE_CYC : 0));
		end
		extra = 0;
		repeat (300) begin
			@(negedge clk_sys);
			if (cass_pulse_o) begin
				extra++;
			end
		end
		check_eq("pulse count", pulse_cyc.size() + extra, n_tap);
		check_eq("tape_loaded_o", tape_loaded_o, 0);
		check_eq("tape_playing_o", tape_playing_o, 0);
		// Tape image as stored in the tape region
		for (int i = 0; i < n_tap; i++) begin
			a = TAPE_BASE + 17'(i);
			read_check(a, model_mem[a]);
		end
		report_test("tape playback");

		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
